//--- rtl/mem_stage_pkg.sv
package mem_stage_pkg;

    // Register data, memory data and byte addresses all share this width
    typedef logic [31:0] word_t;

    typedef logic [3:0] byte_mask_t;  // Bit k enables byte lane k

    // Load modes decoded from the instruction
    typedef enum logic [2:0] {
        MEM_READ_NONE,
        MEM_READ_BYTE,
        MEM_READ_UNSIGN_BYTE,
        MEM_READ_HALF,
        MEM_READ_UNSIGN_HALF,
        MEM_READ_WORD,
        MEM_READ_LWL,
        MEM_READ_LWR
    } mem_read_t;

    // Store modes; SWL and SWR write only part of the word
    typedef enum logic [2:0] {
        MEM_WRITE_NONE,
        MEM_WRITE_BYTE,
        MEM_WRITE_HALF,
        MEM_WRITE_WORD,
        MEM_WRITE_SWL,
        MEM_WRITE_SWR
    } mem_write_t;

endpackage

//--- rtl/stage_memory_load_store.sv
`timescale 1ns/1ps

module stage_memory_load_store import mem_stage_pkg::*; (
    input  mem_read_t  read_mode,
    input  mem_write_t write_mode,
    input  logic       write_mem,
    input  word_t      data_in,
    input  word_t      addr_in,
    input  word_t      mem_dout,
    output logic       mem_write,
    output byte_mask_t mem_mask,
    output word_t      mem_din,
    output word_t      data_out,
    output logic       address_error
);

    logic [1:0]  byte_index;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        half_access;
    logic        word_access;
    word_t       lwl_keep;
    word_t       lwr_keep;

    assign mem_write  = write_mem;
    assign byte_index = addr_in[1:0];

    // Lanes picked out of the memory word for the narrow loads
    assign sel_byte = mem_dout[{byte_index, 3'b000} +: 8];
    assign sel_half = mem_dout[{byte_index[1], 4'b0000} +: 16];

    // Register bytes that survive the merge
    assign lwl_keep = 32'h00ff_ffff >> {byte_index, 3'b000};
    assign lwr_keep = ~(32'hffff_ffff >> {byte_index, 3'b000});

    assign half_access = (read_mode inside {MEM_READ_HALF, MEM_READ_UNSIGN_HALF})
                         || (write_mode == MEM_WRITE_HALF);
    assign word_access = (read_mode == MEM_READ_WORD) || (write_mode == MEM_WRITE_WORD);

    assign address_error = (half_access && byte_index[0]) || (word_access && (|byte_index));

    always_comb begin
        data_out = '0;
        if (!address_error) begin
            case (read_mode)
                MEM_READ_BYTE:        data_out = {{24{sel_byte[7]}}, sel_byte};
                MEM_READ_UNSIGN_BYTE: data_out = {24'h0, sel_byte};
                MEM_READ_HALF:        data_out = {{16{sel_half[15]}}, sel_half};
                MEM_READ_UNSIGN_HALF: data_out = {16'h0, sel_half};
                MEM_READ_WORD:        data_out = mem_dout;
                MEM_READ_LWL: begin
                    // Low memory bytes land in the top of the register
                    data_out = (data_in & lwl_keep) | (mem_dout << {~byte_index, 3'b000});
                end
                MEM_READ_LWR: begin
                    data_out = (data_in & lwr_keep) | (mem_dout >> {byte_index, 3'b000});
                end
                default:              data_out = '0;
            endcase
        end
    end

    always_comb begin
        case (write_mode)
            MEM_WRITE_BYTE: begin
                mem_mask = 4'b0001 << byte_index;
                mem_din  = data_in << {byte_index, 3'b000};
            end
            MEM_WRITE_HALF: begin
                mem_mask = 4'b0011 << {byte_index[1], 1'b0};
                mem_din  = data_in << {byte_index[1], 4'b0000};
            end
            MEM_WRITE_WORD: begin
                mem_mask = 4'b1111;
                mem_din  = data_in;
            end
            MEM_WRITE_SWL: begin
                // Top register bytes go to memory bytes 0 up to the index
                mem_mask = 4'b1111 >> ~byte_index;
                mem_din  = data_in >> {~byte_index, 3'b000};
            end
            MEM_WRITE_SWR: begin
                mem_mask = 4'b1111 << byte_index;
                mem_din  = data_in << {byte_index, 3'b000};
            end
            default: begin
                mem_mask = '0;
                mem_din  = '0;
            end
        endcase
    end

    // The controller must already have blocked the write of a misaligned store
    a_no_write_on_error: assert property (@(posedge mem_write) !address_error)
        else $error("memory write issued for a misaligned access");

endmodule

//--- rtl/data_memory.sv
`timescale 1ns/1ps

module data_memory import mem_stage_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  mem_write,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  byte_mask_t            mem_mask,
    input  word_t                 mem_din,
    output word_t                 mem_dout
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    word_t mem [DEPTH];

    // Byte lanes are written independently under the mask
    always_ff @(posedge clk) begin
        if (mem_write) begin
            for (int k = 0; k < 4; k++) begin
                if (mem_mask[k]) begin
                    mem[mem_addr][8*k +: 8] <= mem_din[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_dout <= mem[mem_addr];  // Old word on a write cycle
    end

    // A store that reaches the memory always touches at least one lane
    a_mask_on_write: assert property (@(posedge clk) mem_write |-> (mem_mask != '0))
        else $error("memory write with an empty byte mask");

endmodule

//--- rtl/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl import mem_stage_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  mem_read_t             read_mode,
    input  mem_write_t            write_mode,
    input  word_t                 addr,
    input  word_t                 data,
    input  logic                  address_error,
    output mem_read_t             cmd_read_mode,
    output mem_write_t            cmd_write_mode,
    output word_t                 cmd_addr,
    output word_t                 cmd_data,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic                  write_mem,
    output logic                  done
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        FINISH
    } state_t;

    state_t state;
    logic   accept;

    assign accept = (state == IDLE) && start;  // Starts in READ or FINISH are dropped

    // Word address; upper address bits wrap
    assign mem_addr = cmd_addr[ADDR_WIDTH+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= IDLE;
            done           <= 1'b0;
            write_mem      <= 1'b0;
            cmd_read_mode  <= MEM_READ_NONE;
            cmd_write_mode <= MEM_WRITE_NONE;
        end else begin
            done      <= 1'b0;
            write_mem <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        cmd_read_mode  <= read_mode;
                        cmd_write_mode <= write_mode;
                        state          <= READ;
                    end
                end
                READ: begin
                    // Alignment is already known from the captured command
                    state     <= FINISH;
                    done      <= 1'b1;
                    write_mem <= (cmd_write_mode != MEM_WRITE_NONE) && !address_error;
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_addr <= addr;
            cmd_data <= data;
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held for more than one cycle");

    a_write_in_finish: assert property (
        @(posedge clk) disable iff (reset) write_mem |-> (state == FINISH)
    ) else $error("write_mem raised outside FINISH");

endmodule

//--- rtl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  mem_read_t  read_mode,
    input  mem_write_t write_mode,
    input  word_t      addr,
    input  word_t      data,
    output logic       done,
    output word_t      load_data,
    output logic       address_error
);

    mem_read_t             cmd_read_mode;
    mem_write_t            cmd_write_mode;
    word_t                 cmd_addr;
    word_t                 cmd_data;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  write_mem;
    logic                  mem_write;
    byte_mask_t            mem_mask;
    word_t                 mem_din;
    word_t                 mem_dout;

    mem_access_ctrl #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_mem_access_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .read_mode     (read_mode),
        .write_mode    (write_mode),
        .addr          (addr),
        .data          (data),
        .address_error (address_error),
        .cmd_read_mode (cmd_read_mode),
        .cmd_write_mode(cmd_write_mode),
        .cmd_addr      (cmd_addr),
        .cmd_data      (cmd_data),
        .mem_addr      (mem_addr),
        .write_mem     (write_mem),
        .done          (done)
    );

    // Register data is the store data and also the old value for LWL/LWR
    stage_memory_load_store i_stage_memory_load_store (
        .read_mode    (cmd_read_mode),
        .write_mode   (cmd_write_mode),
        .write_mem    (write_mem),
        .data_in      (cmd_data),
        .addr_in      (cmd_addr),
        .mem_dout     (mem_dout),
        .mem_write    (mem_write),
        .mem_mask     (mem_mask),
        .mem_din      (mem_din),
        .data_out     (load_data),
        .address_error(address_error)
    );

    data_memory #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_data_memory (
        .clk      (clk),
        .mem_write(mem_write),
        .mem_addr (mem_addr),
        .mem_mask (mem_mask),
        .mem_din  (mem_din),
        .mem_dout (mem_dout)
    );

endmodule

//--- tb/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage import mem_stage_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       start;
    mem_read_t  read_mode;
    mem_write_t write_mode;
    word_t      addr;
    word_t      data;
    logic       done;
    word_t      load_data;
    logic       address_error;

    logic [7:0] model_mem [1024];  // Byte image of the default 256-word memory
    int         errors;
    int         checks;
    int         tests;
    int         seed;

    mem_stage_top i_mem_stage_top (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .read_mode    (read_mode),
        .write_mode   (write_mode),
        .addr         (addr),
        .data         (data),
        .done         (done),
        .load_data    (load_data),
        .address_error(address_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic word_t rand_base();
        return rand_word() & 32'hffff_fffc;  // Aligned, upper bits wrap in the DUT
    endfunction

    function automatic void set_byte(word_t a, int lane, logic [7:0] v);
        model_mem[{a[9:2], 2'(lane)}] = v;
    endfunction

    function automatic word_t model_word(word_t a);
        word_t w;
        for (int k = 0; k < 4; k++) w[8*k +: 8] = model_mem[{a[9:2], 2'(k)}];
        return w;
    endfunction

    // Stores follow the lane rules byte by byte
    function automatic void model_store(mem_write_t wm, word_t a, word_t d);
        int b;
        int h;
        b = int'(a[1:0]);
        h = 2 * int'(a[1]);
        case (wm)
            MEM_WRITE_BYTE: set_byte(a, b, d[7:0]);
            MEM_WRITE_HALF: begin
                set_byte(a, h, d[7:0]);
                set_byte(a, h + 1, d[15:8]);
            end
            MEM_WRITE_WORD: for (int k = 0; k < 4; k++) set_byte(a, k, d[8*k +: 8]);
            MEM_WRITE_SWL:  for (int k = 0; k <= b; k++) set_byte(a, k, d[8*(3-b+k) +: 8]);
            MEM_WRITE_SWR:  for (int k = b; k < 4; k++) set_byte(a, k, d[8*(k-b) +: 8]);
            default: ;
        endcase
    endfunction

    function automatic word_t expect_load(mem_read_t rm, word_t a, word_t old);
        word_t       w;
        word_t       r;
        int          b;
        logic [7:0]  bt;
        logic [15:0] hw;
        w  = model_word(a);
        b  = int'(a[1:0]);
        bt = w[8*b +: 8];
        hw = w[16*int'(a[1]) +: 16];
        r  = '0;
        case (rm)
            MEM_READ_BYTE:        r = {{24{bt[7]}}, bt};
            MEM_READ_UNSIGN_BYTE: r = {24'h0, bt};
            MEM_READ_HALF:        r = {{16{hw[15]}}, hw};
            MEM_READ_UNSIGN_HALF: r = {16'h0, hw};
            MEM_READ_WORD:        r = w;
            MEM_READ_LWL: begin
                r = old;
                for (int k = 0; k <= b; k++) r[8*(3-b+k) +: 8] = w[8*k +: 8];
            end
            MEM_READ_LWR: begin
                r = old;
                for (int k = b; k < 4; k++) r[8*(k-b) +: 8] = w[8*k +: 8];
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic compare_word(input word_t got, input word_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, address_error %b, expected %b", $time, msg, got, exp);
        end
    endtask

    // One command; results are sampled on the falling edge of the done cycle
    task automatic run_cmd(input mem_read_t rm, input mem_write_t wm, input word_t a,
                           input word_t d, output word_t ld, output logic err);
        int   cyc;
        logic seen;
        @(posedge clk);
        start      <= 1'b1;
        read_mode  <= rm;
        write_mode <= wm;
        addr       <= a;
        data       <= d;
        cyc  = 0;
        seen = 1'b0;
        while (!seen && cyc < 10) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                start <= 1'b0;
                cyc++;
            end
        end
        checks++;
        if (!seen) begin
            errors++;
            ld  = 'x;
            err = 1'bx;
            $display("Timeout: no done within 10 cycles of a start at time %0t", $time);
        end else begin
            ld  = load_data;
            err = address_error;
            if (cyc != 2) begin
                errors++;
                $display("Fail at %0t: done came %0d cycles after start, expected 2", $time, cyc);
            end
        end
    endtask

    task automatic do_store(input mem_write_t wm, input word_t a, input word_t d,
                            input string what);
        word_t ld;
        logic  err;
        run_cmd(MEM_READ_NONE, wm, a, d, ld, err);
        compare_flag(err, 1'b0, what);
        compare_word(ld, '0, {what, " load_data"});
        model_store(wm, a, d);
    endtask

    task automatic do_load(input mem_read_t rm, input word_t a, input word_t old,
                           input string what);
        word_t ld;
        logic  err;
        run_cmd(rm, MEM_WRITE_NONE, a, old, ld, err);
        compare_word(ld, expect_load(rm, a, old), what);
        compare_flag(err, 1'b0, what);
    endtask

    // A misaligned command must flag the error and return zero
    task automatic misaligned_cmd(input mem_read_t rm, input mem_write_t wm, input word_t a,
                                  input word_t d, input string what);
        word_t ld;
        logic  err;
        run_cmd(rm, wm, a, d, ld, err);
        compare_flag(err, 1'b1, what);
        compare_word(ld, '0, {what, " load_data"});
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("%s finished with %0d errors", name, errors - err0);
    endtask

    task automatic test_word_rw();
        int    err0;
        word_t a;
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = rand_base();
            do_store(MEM_WRITE_WORD, a, rand_word(), "word store");
            do_load(MEM_READ_WORD, a, '0, $sformatf("word load at %h", a));
        end
        report_test("word_rw", err0);
    endtask

    task automatic test_narrow_rw();
        int    err0;
        word_t base;
        word_t a;
        err0 = errors;
        for (int b = 0; b < 4; b++) begin
            base = rand_base();
            a    = base | word_t'(b);
            do_store(MEM_WRITE_WORD, base, rand_word(), "init word");
            do_store(MEM_WRITE_BYTE, a, rand_word(), $sformatf("byte store b=%0d", b));
            do_load(MEM_READ_BYTE, a, '0, $sformatf("signed byte b=%0d", b));
            do_load(MEM_READ_UNSIGN_BYTE, a, '0, $sformatf("unsigned byte b=%0d", b));
            do_load(MEM_READ_WORD, base, '0, $sformatf("word after byte b=%0d", b));
            if (b % 2 == 0) begin
                do_store(MEM_WRITE_HALF, a, rand_word(), $sformatf("half store b=%0d", b));
                do_load(MEM_READ_HALF, a, '0, $sformatf("signed half b=%0d", b));
                do_load(MEM_READ_UNSIGN_HALF, a, '0, $sformatf("unsigned half b=%0d", b));
                do_load(MEM_READ_WORD, base, '0, $sformatf("word after half b=%0d", b));
            end
        end
        report_test("narrow_rw", err0);
    endtask

    task automatic test_lwl_lwr();
        int    err0;
        word_t base;
        err0 = errors;
        for (int b = 0; b < 4; b++) begin
            base = rand_base();
            do_store(MEM_WRITE_WORD, base, rand_word(), "init word");
            do_load(MEM_READ_LWL, base | word_t'(b), rand_word(), $sformatf("LWL b=%0d", b));
            do_load(MEM_READ_LWR, base | word_t'(b), rand_word(), $sformatf("LWR b=%0d", b));
        end
        report_test("lwl_lwr", err0);
    endtask

    task automatic test_swl_swr();
        int    err0;
        word_t base;
        err0 = errors;
        for (int b = 0; b < 4; b++) begin
            base = rand_base();
            do_store(MEM_WRITE_WORD, base, rand_word(), "init word");
            do_store(MEM_WRITE_SWL, base | word_t'(b), rand_word(), "SWL");
            do_load(MEM_READ_WORD, base, '0, $sformatf("word after SWL b=%0d", b));
            do_store(MEM_WRITE_WORD, base, rand_word(), "init word");
            do_store(MEM_WRITE_SWR, base | word_t'(b), rand_word(), "SWR");
            do_load(MEM_READ_WORD, base, '0, $sformatf("word after SWR b=%0d", b));
        end
        report_test("swl_swr", err0);
    endtask

    // Misaligned stores never reach the model, so the word loads check that memory held still
    task automatic test_misaligned();
        int    err0;
        word_t base;
        err0 = errors;
        for (int b = 1; b < 4; b++) begin
            base = rand_base();
            do_store(MEM_WRITE_WORD, base, rand_word(), "init word");
            misaligned_cmd(MEM_READ_NONE, MEM_WRITE_WORD, base | word_t'(b), rand_word(),
                           "misaligned word store");
            misaligned_cmd(MEM_READ_WORD, MEM_WRITE_NONE, base | word_t'(b), '0,
                           "misaligned word load");
            if (b % 2 == 1) begin
                misaligned_cmd(MEM_READ_NONE, MEM_WRITE_HALF, base | word_t'(b), rand_word(),
                               "misaligned half store");
                misaligned_cmd(MEM_READ_HALF, MEM_WRITE_NONE, base | word_t'(b), '0,
                               "misaligned half load");
                misaligned_cmd(MEM_READ_UNSIGN_HALF, MEM_WRITE_NONE, base | word_t'(b), '0,
                               "misaligned uhalf load");
            end
            do_load(MEM_READ_WORD, base, '0, $sformatf("word after misaligned b=%0d", b));
        end
        report_test("misaligned", err0);
    endtask

    task automatic test_second_start();
        int    err0;
        int    pulses;
        word_t base;
        word_t d1;
        err0 = errors;
        base = rand_base();
        d1   = rand_word();
        do_store(MEM_WRITE_WORD, base, rand_word(), "init word");
        @(posedge clk);
        start      <= 1'b1;
        read_mode  <= MEM_READ_NONE;
        write_mode <= MEM_WRITE_WORD;
        addr       <= base;
        data       <= d1;
        @(posedge clk);
        data <= rand_word();  // Held into the READ cycle
        @(posedge clk);
        start <= 1'b0;
        pulses = 0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (done) pulses++;
        end
        checks++;
        if (pulses != 1) begin
            errors++;
            $display("Fail at %0t: %0d done pulses after a second start, expected 1",
                     $time, pulses);
        end
        model_store(MEM_WRITE_WORD, base, d1);
        do_load(MEM_READ_WORD, base, '0, "word after second start");
        report_test("second_start", err0);
    endtask

    initial begin
        seed       = 32'h65a6;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        reset      = 1'b1;
        start      = 1'b0;
        read_mode  = MEM_READ_NONE;
        write_mode = MEM_WRITE_NONE;
        addr       = '0;
        data       = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_word_rw();
        test_narrow_rw();
        test_lwl_lwr();
        test_swl_swr();
        test_misaligned();
        test_second_start();
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- mem_stage.f
rtl/mem_stage_pkg.sv
rtl/stage_memory_load_store.sv
rtl/data_memory.sv
rtl/mem_access_ctrl.sv
rtl/mem_stage_top.sv
tb/tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only when the pass line appears
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f mem_stage.f --top-module tb_mem_stage \
    || { echo "Build failed"; exit 1; }

out="$(./obj_dir/Vtb_mem_stage)"
echo "$out"

grep -qx "all tests passed" <<< "$out" \
    && { echo "Simulation PASS"; exit 0; } \
    || { echo "Simulation FAIL"; exit 1; }
